// File: rtl/noc_dma_pkg.sv
package noc_dma_pkg;

  // ==============================
  // widths and geometry
  // ==============================
  localparam int ADDR_W         = 32;
  localparam int FLIT_W         = 256;
  localparam int BEAT_SHIFT     = 5;
  localparam int WORDS_PER_BEAT = 8;
  localparam int NUM_SLOTS      = 6;
  localparam int SLOT_W         = 3;

  typedef logic [3:0]  node_id_t;
  // 1..8192 beats
  typedef logic [13:0] len_t;

  typedef struct packed {
    logic [NUM_SLOTS-1:0][ADDR_W-1:0] base;
    logic [NUM_SLOTS-1:0][ADDR_W-1:0] group_base;
    logic [NUM_SLOTS-1:0][ADDR_W-1:0] write_base;
  } base_cfg_t;

  // ==============================
  // flit layouts
  // ==============================
  typedef struct packed {
    logic         pad0;
    logic         group_sel;
    logic [42:0]  pad1;
    logic [11:0]  reply_route;
    logic [116:0] pad2;
    logic [12:0]  len_m1;
    logic [24:0]  pad3;
    logic [24:0]  beat_offset;
    // low nibble is the requesting node
    logic [11:0]  route;
    logic         pad4;
    logic         tag;
    logic [4:0]   pad5;
  } rd_req_flit_t;

  typedef struct packed {
    logic [199:0] pad_hi;
    logic [12:0]  len_m1;
    logic [24:0]  beat_offset;
    node_id_t     node;
    logic         tag;
    logic [12:0]  pad_lo;
  } wr_hdr_t;

  // first flit of a write packet is a header, the rest is payload
  typedef union packed {
    wr_hdr_t           hdr;
    logic [FLIT_W-1:0] raw;
  } noc_flit_u;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    // count in 32-bit words
    logic [31:0]       num;
  } dma_cmd_t;

  typedef struct packed {
    logic [11:0] route;
    logic        tag;
    logic [11:0] reply_route;
    len_t        beats;
  } rd_head_t;

  // left/right pairs share a slot: 0/2, 1/3, 4/6, 5/7, 8/10, 9/11
  // nodes 12..15 land on 6 or 7, past the last slot
  function automatic logic [SLOT_W-1:0] slot_of(node_id_t node);
    return {node[3:2], node[0]};
  endfunction

endpackage

// File: rtl/fwd_slice.sv
module fwd_slice #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  logic [WIDTH-1:0] in_data,
  output logic             in_ready,
  output logic             out_valid,
  output logic [WIDTH-1:0] out_data,
  input  logic             out_ready
);

  // the stage frees up in the same cycle its content leaves
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= in_data;
    end
  end

  // producer keeps valid and payload until the stage takes them
  in_hold: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && !in_ready |=> in_valid && $stable(in_data));

endmodule

// File: rtl/read_req_queue.sv
module read_req_queue #(
  parameter int REQ_DEPTH = 8
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  noc_dma_pkg::base_cfg_t    cfg,
  input  logic                      ctrl_in_valid,
  input  noc_dma_pkg::rd_req_flit_t ctrl_in_flit,
  output logic                      ctrl_in_ready,
  output logic                      rd_req,
  output noc_dma_pkg::dma_cmd_t     rd_cmd,
  input  logic                      rd_addr_ready,
  input  logic                      head_pop,
  output logic                      head_avail,
  output noc_dma_pkg::rd_head_t     head
);

  localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;

  logic [noc_dma_pkg::SLOT_W-1:0] slot;
  logic [noc_dma_pkg::ADDR_W-1:0] base;
  logic [noc_dma_pkg::ADDR_W-1:0] byte_off;
  noc_dma_pkg::len_t              beats;
  noc_dma_pkg::dma_cmd_t          cmd;
  noc_dma_pkg::rd_head_t          entry;
  logic                           cmd_ready;
  logic                           running;
  logic                           full;
  logic                           push;
  noc_dma_pkg::rd_head_t          mem [REQ_DEPTH];
  logic [PTR_W-1:0]               wr_ptr;
  logic [PTR_W-1:0]               rd_ptr;
  logic [PTR_W:0]                 count;

  // ==============================
  // request decode
  // ==============================
  always_comb begin
    slot = noc_dma_pkg::slot_of(ctrl_in_flit.route[3:0]);
    base = '0;
    // group_sel picks the group base table
    if (slot < noc_dma_pkg::NUM_SLOTS) begin
      base = ctrl_in_flit.group_sel ? cfg.group_base[slot] : cfg.base[slot];
    end
    byte_off          = ctrl_in_flit.beat_offset;
    beats             = {1'b0, ctrl_in_flit.len_m1} + 14'd1;
    cmd.addr          = base + (byte_off << noc_dma_pkg::BEAT_SHIFT);
    cmd.num           = 32'(beats) * 32'(noc_dma_pkg::WORDS_PER_BEAT);
    entry.route       = ctrl_in_flit.route;
    entry.tag         = ctrl_in_flit.tag;
    entry.reply_route = ctrl_in_flit.reply_route;
    entry.beats       = beats;
  end

  // ready held off for one cycle out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running <= 1'b0;
    end else begin
      running <= 1'b1;
    end
  end

  assign full          = (count == (PTR_W+1)'(REQ_DEPTH));
  assign ctrl_in_ready = running && !full && cmd_ready;
  assign push          = ctrl_in_valid && ctrl_in_ready;
  assign head_avail    = (count != '0);
  assign head          = mem[rd_ptr];

  fwd_slice #(
    .WIDTH ($bits(noc_dma_pkg::dma_cmd_t))
  ) u_cmd_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (ctrl_in_valid && running && !full),
    .in_data   (cmd),
    .in_ready  (cmd_ready),
    .out_valid (rd_req),
    .out_data  (rd_cmd),
    .out_ready (rd_addr_ready)
  );

  // ==============================
  // head info ring buffer
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (head_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !head_pop) begin
        count <= count + 1'b1;
      end else if (!push && head_pop) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= entry;
    end
  end

  // a push never lands on the unread head entry
  no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push && head_avail |-> (wr_ptr != rd_ptr));

  // the read FSM only pops what the queue holds
  pop_has_entry: assert property (@(posedge clk) disable iff (!rst_n)
    head_pop |-> head_avail);

endmodule

// File: rtl/read_data_sender.sv
module read_data_sender (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            head_pop,
  input  noc_dma_pkg::rd_head_t           head,
  output logic                            send_ready,
  input  logic                            rd_stream,
  input  logic                            rd_data_valid,
  input  logic [noc_dma_pkg::FLIT_W-1:0]  rd_data,
  output logic                            rd_data_ready,
  output logic                            rd_last_done,
  output logic                            data_out_valid,
  output logic [noc_dma_pkg::FLIT_W-1:0]  data_out_flit,
  output logic                            data_out_last,
  input  logic                            data_out_ready
);

  logic [noc_dma_pkg::FLIT_W-1:0] head_flit;
  noc_dma_pkg::len_t              total;
  noc_dma_pkg::len_t              beat_cnt;
  logic                           is_last;
  logic                           rd_hs;
  logic                           slice_valid;
  logic                           slice_ready;
  logic [noc_dma_pkg::FLIT_W:0]   slice_data;

  // head flit: route, marker bit, tag, reply route up at 171:160
  always_comb begin
    head_flit          = '0;
    head_flit[11:0]    = head.route;
    head_flit[12]      = 1'b1;
    head_flit[13]      = head.tag;
    head_flit[171:160] = head.reply_route;
  end

  assign send_ready    = slice_ready;
  assign rd_data_ready = rd_stream && slice_ready;
  assign rd_hs         = rd_data_valid && rd_data_ready;
  assign is_last       = (beat_cnt == total - 14'd1);
  assign rd_last_done  = rd_hs && is_last;

  // head and beats never compete, pop only happens outside streaming
  assign slice_valid = head_pop || (rd_stream && rd_data_valid);
  assign slice_data  = head_pop ? {1'b0, head_flit} : {is_last, rd_data};

  // ==============================
  // beat counter
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      total    <= '0;
      beat_cnt <= '0;
    end else if (head_pop) begin
      total    <= head.beats;
      beat_cnt <= '0;
    end else if (rd_hs) begin
      beat_cnt <= is_last ? '0 : beat_cnt + 14'd1;
    end
  end

  fwd_slice #(
    .WIDTH (noc_dma_pkg::FLIT_W + 1)
  ) u_out_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (slice_valid),
    .in_data   (slice_data),
    .in_ready  (slice_ready),
    .out_valid (data_out_valid),
    .out_data  ({data_out_last, data_out_flit}),
    .out_ready (data_out_ready)
  );

endmodule

// File: rtl/write_req_tracker.sv
module write_req_tracker (
  input  logic                            clk,
  input  logic                            rst_n,
  input  noc_dma_pkg::base_cfg_t          cfg,
  input  logic                            data_in_valid,
  input  noc_dma_pkg::noc_flit_u          data_in_flit,
  output logic                            data_in_ready,
  input  logic                            wr_hdr_en,
  input  logic                            wr_stream,
  input  logic                            resp_en,
  output logic                            wr_hdr_seen,
  output logic                            wr_last_done,
  output logic                            wr_req,
  output noc_dma_pkg::dma_cmd_t           wr_cmd,
  input  logic                            wr_addr_ready,
  output logic                            wr_data_valid,
  output logic [noc_dma_pkg::FLIT_W-1:0]  wr_data,
  input  logic                            wr_data_ready,
  output logic                            ctrl_out_valid,
  output logic [noc_dma_pkg::FLIT_W-1:0]  ctrl_out_flit,
  input  logic                            ctrl_out_ready,
  output logic                            resp_done
);

  logic [noc_dma_pkg::SLOT_W-1:0] slot;
  logic [noc_dma_pkg::ADDR_W-1:0] base;
  logic [noc_dma_pkg::ADDR_W-1:0] byte_off;
  noc_dma_pkg::len_t              beats;
  noc_dma_pkg::dma_cmd_t          cmd;
  logic                           cmd_valid;
  logic                           cmd_ready;
  logic                           hdr_hs;
  logic                           wr_hs;
  logic                           is_last;
  noc_dma_pkg::node_id_t          node_q;
  logic                           tag_q;
  noc_dma_pkg::len_t              total;
  noc_dma_pkg::len_t              beat_cnt;

  // ==============================
  // header decode
  // ==============================
  always_comb begin
    slot = noc_dma_pkg::slot_of(data_in_flit.hdr.node);
    base = '0;
    if (slot < noc_dma_pkg::NUM_SLOTS) begin
      base = cfg.write_base[slot];
    end
    byte_off = data_in_flit.hdr.beat_offset;
    beats    = {1'b0, data_in_flit.hdr.len_m1} + 14'd1;
    cmd.addr = base + (byte_off << noc_dma_pkg::BEAT_SHIFT);
    cmd.num  = 32'(beats) * 32'(noc_dma_pkg::WORDS_PER_BEAT);
  end

  // header waits on the command slice, payload on the DMA
  assign data_in_ready = wr_hdr_en ? cmd_ready : (wr_stream && wr_data_ready);
  assign cmd_valid     = wr_hdr_en && data_in_valid;
  assign hdr_hs        = cmd_valid && cmd_ready;
  assign wr_hdr_seen   = hdr_hs;

  assign wr_data_valid = wr_stream && data_in_valid;
  assign wr_data       = data_in_flit.raw;
  assign wr_hs         = wr_data_valid && wr_data_ready;
  assign is_last       = (beat_cnt == total - 14'd1);
  assign wr_last_done  = wr_hs && is_last;

  fwd_slice #(
    .WIDTH ($bits(noc_dma_pkg::dma_cmd_t))
  ) u_cmd_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (cmd_valid),
    .in_data   (cmd),
    .in_ready  (cmd_ready),
    .out_valid (wr_req),
    .out_data  (wr_cmd),
    .out_ready (wr_addr_ready)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      total    <= '0;
      beat_cnt <= '0;
    end else if (hdr_hs) begin
      total    <= beats;
      beat_cnt <= '0;
    end else if (wr_hs) begin
      beat_cnt <= is_last ? '0 : beat_cnt + 14'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_hs) begin
      node_q <= data_in_flit.hdr.node;
      tag_q  <= data_in_flit.hdr.tag;
    end
  end

  // ==============================
  // write response
  // ==============================
  always_comb begin
    ctrl_out_flit      = '0;
    ctrl_out_flit[3:0] = node_q;
    ctrl_out_flit[4]   = 1'b1;
    ctrl_out_flit[5]   = tag_q;
  end

  assign ctrl_out_valid = resp_en;
  assign resp_done      = resp_en && ctrl_out_ready;

endmodule

// File: rtl/bridge_ctrl.sv
module bridge_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic head_avail,
  input  logic send_ready,
  input  logic rd_last_done,
  input  logic wr_hdr_seen,
  input  logic wr_last_done,
  input  logic wr_done,
  input  logic resp_done,
  output logic head_pop,
  output logic rd_stream,
  output logic wr_hdr_en,
  output logic wr_stream,
  output logic resp_en
);

  localparam logic       IDLE   = 1'b0;
  localparam logic       STREAM = 1'b1;

  localparam logic [1:0] W_IDLE = 2'd0;
  localparam logic [1:0] W_DATA = 2'd1;
  localparam logic [1:0] W_WAIT = 2'd2;
  localparam logic [1:0] W_RESP = 2'd3;

  logic       rd_state;
  logic       rd_next;
  logic [1:0] wr_state;
  logic [1:0] wr_next;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_state <= IDLE;
      wr_state <= W_IDLE;
    end else begin
      rd_state <= rd_next;
      wr_state <= wr_next;
    end
  end

  // ==============================
  // read FSM
  // ==============================
  // pop the next head only when the output slice can take it
  assign head_pop  = (rd_state == IDLE) && head_avail && send_ready;
  assign rd_stream = (rd_state == STREAM);

  always_comb begin
    rd_next = rd_state;
    case (rd_state)
      IDLE:   if (head_pop) rd_next = STREAM;
      STREAM: if (rd_last_done) rd_next = IDLE;
      default: rd_next = IDLE;
    endcase
  end

  // ==============================
  // write FSM
  // ==============================
  assign wr_hdr_en = (wr_state == W_IDLE);
  assign wr_stream = (wr_state == W_DATA);
  assign resp_en   = (wr_state == W_RESP);

  always_comb begin
    wr_next = wr_state;
    case (wr_state)
      W_IDLE: if (wr_hdr_seen) wr_next = W_DATA;
      W_DATA: if (wr_last_done) wr_next = W_WAIT;
      // completion latency of the DMA is open ended
      W_WAIT: if (wr_done) wr_next = W_RESP;
      W_RESP: if (resp_done) wr_next = W_IDLE;
      default: wr_next = W_IDLE;
    endcase
  end

  // last beats come back only in the state that streams them
  last_in_stream: assert property (@(posedge clk) disable iff (!rst_n)
    rd_last_done |-> (rd_state == STREAM));

  last_in_data: assert property (@(posedge clk) disable iff (!rst_n)
    wr_last_done |-> (wr_state == W_DATA));

endmodule

// File: rtl/noc_dma_bridge.sv
module noc_dma_bridge #(
  parameter int REQ_DEPTH = 8
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  noc_dma_pkg::base_cfg_t          cfg,
  // NoC control channel
  input  logic                            ctrl_in_valid,
  input  noc_dma_pkg::rd_req_flit_t       ctrl_in_flit,
  output logic                            ctrl_in_ready,
  output logic                            ctrl_out_valid,
  output logic [noc_dma_pkg::FLIT_W-1:0]  ctrl_out_flit,
  input  logic                            ctrl_out_ready,
  // NoC data channel
  input  logic                            data_in_valid,
  input  noc_dma_pkg::noc_flit_u          data_in_flit,
  output logic                            data_in_ready,
  output logic                            data_out_valid,
  output logic [noc_dma_pkg::FLIT_W-1:0]  data_out_flit,
  output logic                            data_out_last,
  input  logic                            data_out_ready,
  // DMA read side
  output logic                            rd_req,
  output noc_dma_pkg::dma_cmd_t           rd_cmd,
  input  logic                            rd_addr_ready,
  input  logic                            rd_data_valid,
  input  logic [noc_dma_pkg::FLIT_W-1:0]  rd_data,
  output logic                            rd_data_ready,
  // DMA write side
  output logic                            wr_req,
  output noc_dma_pkg::dma_cmd_t           wr_cmd,
  input  logic                            wr_addr_ready,
  output logic                            wr_data_valid,
  output logic [noc_dma_pkg::FLIT_W-1:0]  wr_data,
  input  logic                            wr_data_ready,
  input  logic                            wr_done
);

  // FSM enables and datapath events
  logic                  head_pop;
  logic                  head_avail;
  noc_dma_pkg::rd_head_t head;
  logic                  send_ready;
  logic                  rd_stream;
  logic                  rd_last_done;
  logic                  wr_hdr_en;
  logic                  wr_stream;
  logic                  resp_en;
  logic                  wr_hdr_seen;
  logic                  wr_last_done;
  logic                  resp_done;

  read_req_queue #(
    .REQ_DEPTH (REQ_DEPTH)
  ) u_read_req_queue (.*);

  read_data_sender u_read_data_sender (.*);

  write_req_tracker u_write_req_tracker (.*);

  bridge_ctrl u_bridge_ctrl (.*);

endmodule

// File: testbench/tb_noc_dma_bridge.sv
module tb_noc_dma_bridge;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int FLIT_W      = noc_dma_pkg::FLIT_W;
  localparam int MAX_LEN     = 8;
  localparam int NUM_TXN     = 64;
  localparam int WATCHDOG_NS = NUM_TXN * MAX_LEN * 40 + 200;

  logic                      clk = 1'b0;
  logic                      rst_n;
  noc_dma_pkg::base_cfg_t    cfg;
  logic                      ctrl_in_valid;
  noc_dma_pkg::rd_req_flit_t ctrl_in_flit;
  logic                      ctrl_in_ready;
  logic                      ctrl_out_valid;
  logic [FLIT_W-1:0]         ctrl_out_flit;
  logic                      ctrl_out_ready;
  logic                      data_in_valid;
  noc_dma_pkg::noc_flit_u    data_in_flit;
  logic                      data_in_ready;
  logic                      data_out_valid;
  logic [FLIT_W-1:0]         data_out_flit;
  logic                      data_out_last;
  logic                      data_out_ready;
  logic                      rd_req;
  noc_dma_pkg::dma_cmd_t     rd_cmd;
  logic                      rd_addr_ready;
  logic                      rd_data_valid;
  logic [FLIT_W-1:0]         rd_data;
  logic                      rd_data_ready;
  logic                      wr_req;
  noc_dma_pkg::dma_cmd_t     wr_cmd;
  logic                      wr_addr_ready;
  logic                      wr_data_valid;
  logic [FLIT_W-1:0]         wr_data;
  logic                      wr_data_ready;
  logic                      wr_done;

  integer seed = 32'hce16_e465;

  // expected traffic built by the stimulus tasks from the model
  noc_dma_pkg::dma_cmd_t exp_rd_cmd[$];
  int                    exp_rd_len[$];
  logic [FLIT_W-1:0]     exp_heads[$];
  int                    exp_head_len[$];
  logic [FLIT_W-1:0]     exp_beats[$];
  int                    rd_len_q[$];
  noc_dma_pkg::dma_cmd_t exp_wr_cmd[$];
  int                    exp_wr_len[$];
  logic [FLIT_W-1:0]     exp_wr_data[$];
  logic [FLIT_W-1:0]     exp_resp[$];

  int out_left      = 0;
  int cur_rd_left   = 0;
  int wr_left       = 0;
  int done_delay    = 0;
  int done_cnt      = 0;
  int resp_cnt      = 0;
  int err_cnt       = 0;
  int test_err_base = 0;
  int pass_cnt      = 0;
  int fail_cnt      = 0;
  bit rd_taken      = 1'b0;
  bit done_pending  = 1'b0;
  bit bp_mode       = 1'b0;

  always #2 clk = ~clk;

  noc_dma_bridge #(
    .REQ_DEPTH (8)
  ) dut (.*);

  // ==============================
  // reference model
  // ==============================
  function automatic int node_slot(logic [3:0] node);
    case (node)
      4'd0, 4'd2:  return 0;
      4'd1, 4'd3:  return 1;
      4'd4, 4'd6:  return 2;
      4'd5, 4'd7:  return 3;
      4'd8, 4'd10: return 4;
      4'd9, 4'd11: return 5;
      default:     return -1;
    endcase
  endfunction

  function automatic noc_dma_pkg::dma_cmd_t model_cmd(logic [31:0] base, logic [24:0] off,
                                                      logic [12:0] len_m1);
    noc_dma_pkg::dma_cmd_t c;
    c.addr = base + 32'(off) * 32;
    c.num  = (32'(len_m1) + 1) * 8;
    return c;
  endfunction

  function automatic logic [FLIT_W-1:0] rand_flit();
    logic [FLIT_W-1:0] v;
    for (int i = 0; i < FLIT_W / 32; i++) begin
      v[i*32 +: 32] = $random(seed);
    end
    return v;
  endfunction

  function automatic bit drained();
    return exp_rd_cmd.size() == 0 && exp_heads.size() == 0 && out_left == 0 &&
           exp_beats.size() == 0 && exp_wr_cmd.size() == 0 &&
           exp_wr_data.size() == 0 && exp_resp.size() == 0 && !done_pending;
  endfunction

  task automatic check_val(input string name, input logic [FLIT_W-1:0] got,
                           input logic [FLIT_W-1:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %0s got %0h expected %0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_error(input string msg);
    err_cnt++;
    $display("error: %0s at %0t", msg, $time);
  endtask

  task automatic begin_test();
    test_err_base = err_cnt;
  endtask

  task automatic end_test(input string name);
    if (err_cnt == test_err_base) begin
      pass_cnt++;
      $display("test %0s: passed", name);
    end else begin
      fail_cnt++;
      $display("test %0s: failed, %0d errors", name, err_cnt - test_err_base);
    end
  endtask

  task automatic wait_drained();
    while (!drained()) @(negedge clk);
    repeat (4) @(negedge clk);
  endtask

  // ==============================
  // NoC stimulus
  // ==============================
  task automatic send_read(input logic [3:0] node, input bit gaps);
    noc_dma_pkg::rd_req_flit_t f;
    logic [FLIT_W-1:0]         head;
    logic [31:0]               base;
    int                        slot;
    f           = rand_flit();
    f.route[3:0] = node;
    f.len_m1    = 13'($unsigned($random(seed)) % MAX_LEN);
    f.group_sel = 1'($random(seed));
    slot        = node_slot(node);
    base        = '0;
    if (slot >= 0) begin
      base = f.group_sel ? cfg.group_base[slot] : cfg.base[slot];
    end
    head          = '0;
    head[11:0]    = f.route;
    head[12]      = 1'b1;
    head[13]      = f.tag;
    head[171:160] = f.reply_route;
    exp_rd_cmd.push_back(model_cmd(base, f.beat_offset, f.len_m1));
    exp_rd_len.push_back(f.len_m1 + 1);
    exp_heads.push_back(head);
    exp_head_len.push_back(f.len_m1 + 1);
    if (gaps) repeat ($unsigned($random(seed)) % 3) @(negedge clk);
    ctrl_in_flit  = f;
    ctrl_in_valid = 1'b1;
    do @(posedge clk); while (!ctrl_in_ready);
    @(negedge clk);
    ctrl_in_valid = 1'b0;
  endtask

  task automatic drive_data_in(input logic [FLIT_W-1:0] flit, input bit gaps);
    if (gaps) repeat ($unsigned($random(seed)) % 3) @(negedge clk);
    data_in_flit.raw = flit;
    data_in_valid    = 1'b1;
    do @(posedge clk); while (!data_in_ready);
    @(negedge clk);
    data_in_valid = 1'b0;
  endtask

  task automatic send_write(input bit gaps);
    noc_dma_pkg::noc_flit_u f;
    logic [FLIT_W-1:0]      beat;
    logic [FLIT_W-1:0]      resp;
    logic [31:0]            base;
    int                     slot;
    int                     beats;
    f.raw        = rand_flit();
    f.hdr.node   = 4'($random(seed));
    f.hdr.len_m1 = 13'($unsigned($random(seed)) % MAX_LEN);
    beats        = f.hdr.len_m1 + 1;
    slot         = node_slot(f.hdr.node);
    base         = (slot >= 0) ? cfg.write_base[slot] : '0;
    resp         = '0;
    resp[3:0]    = f.hdr.node;
    resp[4]      = 1'b1;
    resp[5]      = f.hdr.tag;
    exp_wr_cmd.push_back(model_cmd(base, f.hdr.beat_offset, f.hdr.len_m1));
    exp_wr_len.push_back(beats);
    exp_resp.push_back(resp);
    drive_data_in(f.raw, gaps);
    repeat (beats) begin
      beat = rand_flit();
      exp_wr_data.push_back(beat);
      drive_data_in(beat, gaps);
    end
  endtask

  // ==============================
  // DMA responder and ready drivers
  // ==============================
  always @(negedge clk) begin : dma_drive
    rd_addr_ready  = ($unsigned($random(seed)) % 4) != 0;
    wr_addr_ready  = ($unsigned($random(seed)) % 4) != 0;
    wr_data_ready  = ($unsigned($random(seed)) % 4) != 0;
    data_out_ready = !bp_mode || ($unsigned($random(seed)) % 3) != 0;
    ctrl_out_ready = !bp_mode || ($unsigned($random(seed)) % 3) != 0;
    // a beat holds until the bridge takes it
    if (!rd_data_valid || rd_taken) begin
      rd_taken      = 1'b0;
      rd_data_valid = 1'b0;
      if (cur_rd_left == 0 && rd_len_q.size() > 0) begin
        cur_rd_left = rd_len_q.pop_front();
      end
      if (cur_rd_left > 0 && ($unsigned($random(seed)) % 4) != 0) begin
        rd_data_valid = 1'b1;
        rd_data       = rand_flit();
        cur_rd_left--;
      end
    end
    wr_done = 1'b0;
    if (done_pending) begin
      if (done_delay > 0) begin
        done_delay--;
      end else begin
        wr_done      = 1'b1;
        done_pending = 1'b0;
      end
    end
  end

  // ==============================
  // monitors and checks
  // ==============================
  always @(posedge clk) begin : monitor
    noc_dma_pkg::dma_cmd_t c;
    if (rst_n) begin
      if (rd_req && rd_addr_ready) begin
        if (exp_rd_cmd.size() == 0) begin
          report_error("rd_req with no read outstanding");
        end else begin
          c = exp_rd_cmd.pop_front();
          check_val("rd_cmd.addr", rd_cmd.addr, c.addr);
          check_val("rd_cmd.num", rd_cmd.num, c.num);
          rd_len_q.push_back(exp_rd_len.pop_front());
        end
      end
      if (rd_data_valid && rd_data_ready) begin
        rd_taken = 1'b1;
        exp_beats.push_back(rd_data);
      end
      if (data_out_valid && data_out_ready) begin
        if (out_left == 0) begin
          if (exp_heads.size() == 0) begin
            report_error("data_out sent a flit nobody asked for");
          end else begin
            check_val("data_out_flit", data_out_flit, exp_heads.pop_front());
            check_val("data_out_last", data_out_last, 1'b0);
            out_left = exp_head_len.pop_front();
          end
        end else if (exp_beats.size() == 0) begin
          report_error("data_out sent a beat the DMA never returned");
        end else begin
          check_val("data_out_flit", data_out_flit, exp_beats.pop_front());
          check_val("data_out_last", data_out_last, out_left == 1);
          out_left--;
        end
      end
      // write side
      if (wr_req && wr_addr_ready) begin
        if (exp_wr_cmd.size() == 0) begin
          report_error("wr_req with no write outstanding");
        end else begin
          c = exp_wr_cmd.pop_front();
          check_val("wr_cmd.addr", wr_cmd.addr, c.addr);
          check_val("wr_cmd.num", wr_cmd.num, c.num);
        end
      end
      if (wr_data_valid && wr_data_ready) begin
        if (exp_wr_data.size() == 0 || (wr_left == 0 && exp_wr_len.size() == 0)) begin
          report_error("wr_data beat beyond the packet length");
        end else begin
          check_val("wr_data", wr_data, exp_wr_data.pop_front());
          if (wr_left == 0) begin
            wr_left = exp_wr_len.pop_front();
          end
          wr_left--;
          if (wr_left == 0) begin
            done_pending = 1'b1;
            done_delay   = $unsigned($random(seed)) % 6;
          end
        end
      end
      if (ctrl_out_valid && done_cnt == resp_cnt) begin
        report_error("write response raised before wr_done");
      end
      if (ctrl_out_valid && ctrl_out_ready) begin
        if (exp_resp.size() == 0) begin
          report_error("write response with no write outstanding");
        end else begin
          check_val("ctrl_out_flit", ctrl_out_flit, exp_resp.pop_front());
        end
        resp_cnt++;
      end
      // a response may only follow a completed pulse
      if (wr_done) begin
        done_cnt++;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("error: run did not finish within %0d ns", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // ==============================
  // test sequence
  // ==============================
  initial begin : main
    int ready_wait;
    rst_n          = 1'b0;
    ctrl_in_valid  = 1'b0;
    ctrl_in_flit   = '0;
    data_in_valid  = 1'b0;
    data_in_flit   = '0;
    data_out_ready = 1'b0;
    ctrl_out_ready = 1'b0;
    rd_addr_ready  = 1'b0;
    rd_data_valid  = 1'b0;
    rd_data        = '0;
    wr_addr_ready  = 1'b0;
    wr_data_ready  = 1'b0;
    wr_done        = 1'b0;
    for (int i = 0; i < noc_dma_pkg::NUM_SLOTS; i++) begin
      cfg.base[i]       = $random(seed);
      cfg.group_base[i] = $random(seed);
      cfg.write_base[i] = $random(seed);
    end

    begin_test();
    repeat (10) @(posedge clk);
    check_val("rd_req", rd_req, 1'b0);
    check_val("wr_req", wr_req, 1'b0);
    check_val("data_out_valid", data_out_valid, 1'b0);
    check_val("ctrl_out_valid", ctrl_out_valid, 1'b0);
    check_val("rd_data_ready", rd_data_ready, 1'b0);
    check_val("wr_data_valid", wr_data_valid, 1'b0);
    @(negedge clk);
    rst_n      = 1'b1;
    ready_wait = 0;
    while (!ctrl_in_ready && ready_wait < 4) begin
      @(posedge clk);
      ready_wait++;
    end
    if (!ctrl_in_ready) begin
      report_error("ctrl_in_ready did not rise after reset");
    end
    @(negedge clk);
    end_test("reset state");

    begin_test();
    for (int i = 0; i < 16; i++) begin
      send_read(4'(i), 1'b1);
    end
    wait_drained();
    end_test("read translation over all nodes");

    begin_test();
    for (int i = 0; i < 8; i++) begin
      send_read(4'($random(seed)), 1'b1);
    end
    wait_drained();
    end_test("read response");

    // back-to-back reads against a stalling consumer
    begin_test();
    bp_mode = 1'b1;
    for (int i = 0; i < 12; i++) begin
      send_read(4'($random(seed)), 1'b0);
    end
    wait_drained();
    end_test("read back-pressure");

    begin_test();
    for (int i = 0; i < 10; i++) begin
      send_write(1'b1);
    end
    wait_drained();
    end_test("write path");

    begin_test();
    fork
      begin
        for (int i = 0; i < 10; i++) begin
          send_read(4'($random(seed)), 1'b1);
        end
      end
      begin
        for (int i = 0; i < 8; i++) begin
          send_write(1'b1);
        end
      end
    join
    wait_drained();
    end_test("concurrent reads and writes");

    $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
rtl/noc_dma_pkg.sv
rtl/fwd_slice.sv
rtl/read_req_queue.sv
rtl/read_data_sender.sv
rtl/write_req_tracker.sv
rtl/bridge_ctrl.sv
rtl/noc_dma_bridge.sv
testbench/tb_noc_dma_bridge.sv

// File: Bender.yml
package:
  name: noc_dma_bridge

sources:
  - files:
      - rtl/noc_dma_pkg.sv
      - rtl/fwd_slice.sv
      - rtl/read_req_queue.sv
      - rtl/read_data_sender.sv
      - rtl/write_req_tracker.sv
      - rtl/bridge_ctrl.sv
      - rtl/noc_dma_bridge.sv
  - target: test
    files:
      - testbench/tb_noc_dma_bridge.sv
